// ==== dv/ntm_forget_gate_asserts.sv ====
/* Checks bound into the forget gate top level. Latency check needs RST
   low over the last three edges; saturation checks watch a_data directly */
`default_nettype none

module ntm_forget_gate_asserts (
  input logic                       CLK,
  input logic                       RST,
  input logic                       in_strobe,
  input logic                       out_strobe,
  input ntm_forget_pkg::pre_stage_t a_data,
  input ntm_forget_pkg::gate_out_t  out_data
);

  // Output strobe is the input strobe three edges late
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    (!$past(RST, 1) && !$past(RST, 2) && !$past(RST, 3))
      |-> (out_strobe == $past(in_strobe, 3)))
    else $error("out_strobe does not follow in_strobe by three cycles");

  // Nothing leaves while in reset
  a_reset_quiet: assert property (@(posedge CLK) RST |-> !out_strobe)
    else $error("out_strobe high during reset");

  ///////////////////////////////////////////////////////////////////////
  // Logistic saturation
  ///////////////////////////////////////////////////////////////////////

  a_sat_high: assert property (@(posedge CLK) disable iff (RST)
    ($signed(a_data.z) >= ntm_forget_pkg::PLAN_SAT)
      |=> (out_data.f == ntm_forget_pkg::GATE_MAX))
    else $error("large positive preactivation did not give 255");

  a_sat_low: assert property (@(posedge CLK) disable iff (RST)
    ($signed(a_data.z) <= -ntm_forget_pkg::PLAN_SAT)
      |=> (out_data.f == 8'd0))   // Mirror of one is zero
    else $error("large negative preactivation did not give 0");

endmodule

bind ntm_forget_gate_vector ntm_forget_gate_asserts u_asserts (
  .CLK        (CLK),
  .RST        (RST),
  .in_strobe  (in_strobe),
  .out_strobe (out_strobe),
  .a_data     (a_data),
  .out_data   (out_data)
);

`default_nettype wire

// ==== dv/ntm_forget_gate_tb.sv ====
/* Forget gate testbench. Integer model of the sum and PLAN logistic, expected
   results queued per row and matched on out_strobe; stops at the first error */
`default_nettype none

module ntm_forget_gate_tb;

  logic                      CLK;
  logic                      RST;
  logic                      in_strobe;
  ntm_forget_pkg::gate_in_t  in_data;
  logic                      out_strobe;
  ntm_forget_pkg::gate_out_t out_data;

  integer seed;                              // $random state
  int     cycle;                             // Rising edges so far
  int     max_wait;                          // Drain timeout in cycles
  string  test_name;
  int     targets [11] = '{0, 255, 256, 257, 607, 608, 609, 1279, 1280, 1281, 2000};

  ntm_forget_pkg::gate_out_t exp_q [$];      // Expected results, oldest first
  int                        due_q [$];      // Edge count at which each is due

  ntm_forget_gate_vector dut (
    .CLK        (CLK),
    .RST        (RST),
    .in_strobe  (in_strobe),
    .in_data    (in_data),
    .out_strobe (out_strobe),
    .out_data   (out_data)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) cycle <= cycle + 1;

  ///////////////////////////////////////////////////////////////////////
  // Reporting and reference model
  ///////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // Exact dot products, then PLAN on the magnitude
  function automatic ntm_forget_pkg::gate_out_t model_gate(input ntm_forget_pkg::gate_in_t d);
    ntm_forget_pkg::gate_out_t res;
    int z;
    int a;
    int g;
    z = int'($signed(d.b)) * 16;             // Q4.4 bias up to Q.8
    for (int i = 0; i < ntm_forget_pkg::VEC_LEN; i++) begin
      z += int'($signed(d.w_row[i])) * int'($signed(d.x[i]));
      z += int'($signed(d.k_row[i])) * int'($signed(d.r[i]));
      z += int'($signed(d.u_row[i])) * int'($signed(d.h[i]));
    end
    a = (z < 0) ? -z : z;
    if (a >= int'(ntm_forget_pkg::PLAN_SAT)) g = 256;
    else if (a >= int'(ntm_forget_pkg::PLAN_MID)) g = (a >> 5) + 216;
    else if (a >= int'(ntm_forget_pkg::PLAN_LOW)) g = (a >> 3) + 160;
    else g = (a >> 2) + 128;
    if (z < 0) g = 256 - g;                  // Fold around one half
    if (g > 255) g = 255;
    res.row = d.row;
    res.f   = ntm_forget_pkg::gate_t'(g);
    return res;
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // Stimulus
  ///////////////////////////////////////////////////////////////////////

  // Sampled at edge cycle+1; third stage register raises out_strobe at edge cycle+3
  task automatic send_row(input ntm_forget_pkg::gate_in_t d,
                          input ntm_forget_pkg::gate_out_t expected);
    in_data   = d;
    in_strobe = 1'b1;
    exp_q.push_back(expected);
    due_q.push_back(cycle + 3);
    @(posedge CLK);
    #1;
    in_strobe = 1'b0;
  endtask

  // Expected result from the integer model
  task automatic drive_row(input ntm_forget_pkg::gate_in_t d);
    send_row(d, model_gate(d));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic random_row(input ntm_forget_pkg::row_t tag,
                            output ntm_forget_pkg::gate_in_t d);
    d.row = tag;
    for (int i = 0; i < ntm_forget_pkg::VEC_LEN; i++) begin
      d.w_row[i] = ntm_forget_pkg::elem_t'($random(seed));
      d.x[i]     = ntm_forget_pkg::elem_t'($random(seed));
      d.k_row[i] = ntm_forget_pkg::elem_t'($random(seed));
      d.r[i]     = ntm_forget_pkg::elem_t'($random(seed));
      d.u_row[i] = ntm_forget_pkg::elem_t'($random(seed));
      d.h[i]     = ntm_forget_pkg::elem_t'($random(seed));
    end
    d.b = ntm_forget_pkg::elem_t'($random(seed));
  endtask

  // z = 16*q + rm with q, rm from |t|; weights 1.0 and 1/16
  task automatic boundary_row(input ntm_forget_pkg::row_t tag, input int t,
                              output ntm_forget_pkg::gate_in_t d);
    int s;
    int m;
    s = (t < 0) ? -1 : 1;
    m = (t < 0) ? -t : t;
    d          = '0;
    d.row      = tag;
    d.w_row[0] = 8'sd16;
    d.x[0]     = ntm_forget_pkg::elem_t'(s * (m / 16));
    d.w_row[1] = 8'sd1;
    d.x[1]     = ntm_forget_pkg::elem_t'(s * (m % 16));
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= max_wait) begin
        $display("Timeout in %s: %0d rows never came out", test_name, exp_q.size());
        abort_run();
      end else begin
        @(posedge CLK);
        #1;
        waited++;
      end
    end
  endtask

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge CLK) begin
    ntm_forget_pkg::gate_out_t head;
    int due;
    if (out_strobe === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Output strobe at cycle %0d in %s with no row in flight", cycle, test_name);
        abort_run();
      end else begin
        head = exp_q.pop_front();
        due  = due_q.pop_front();
        check_value("row", int'(head.row), int'(out_data.row));
        check_value("f", int'(head.f), int'(out_data.f));
        check_value("latency", due, cycle);  // Also proves in-order, back to back
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Test sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    ntm_forget_pkg::gate_in_t  d;
    ntm_forget_pkg::gate_out_t known;
    int gap;
    seed      = 52;
    cycle     = 0;
    max_wait  = 64;
    test_name = "reset";
    RST       = 1'b1;
    in_strobe = 1'b0;
    in_data   = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    test_name = "random_gaps";
    for (int n = 0; n < 200; n++) begin
      random_row(ntm_forget_pkg::row_t'(n), d);
      drive_row(d);
      gap = {$random(seed)} % 4;             // 0..3 idle cycles
      idle_cycles(gap);
    end
    wait_drain();

    test_name = "burst_32";
    for (int n = 0; n < 32; n++) begin
      random_row(ntm_forget_pkg::row_t'(n), d);
      drive_row(d);
    end
    wait_drain();

    test_name = "zero_weights";
    for (int n = 0; n < 20; n++) begin
      random_row(ntm_forget_pkg::row_t'(n), d);
      d.w_row = '0;
      d.k_row = '0;
      d.u_row = '0;
      d.b     = '0;
      known.row = d.row;
      known.f   = 8'd128;                    // One half at zero
      send_row(d, known);
    end
    wait_drain();

    test_name = "boundaries";
    for (int n = 0; n < 22; n++) begin
      boundary_row(ntm_forget_pkg::row_t'(n), (n < 11) ? targets[n] : -targets[n - 11], d);
      drive_row(d);
    end
    d       = '0;
    d.w_row = {4{8'sd127}};                  // All products +127*127
    d.x     = {4{8'sd127}};
    d.k_row = {4{8'sd127}};
    d.r     = {4{8'sd127}};
    d.u_row = {4{8'sd127}};
    d.h     = {4{8'sd127}};
    d.b     = 8'sd127;
    known.row = d.row;
    known.f   = 8'd255;
    send_row(d, known);
    d.x = {4{-8'sd128}};                     // Flip operands, products negative
    d.r = {4{-8'sd128}};
    d.h = {4{-8'sd128}};
    d.b = -8'sd128;
    known.row = d.row;
    known.f   = 8'd0;
    send_row(d, known);
    wait_drain();

    test_name = "reset_flush";
    for (int n = 0; n < 3; n++) begin
      random_row(ntm_forget_pkg::row_t'(n), d);
      drive_row(d);
    end
    RST = 1'b1;                              // Three rows still in the pipe
    exp_q.delete();
    due_q.delete();
    idle_cycles(2);
    RST = 1'b0;
    idle_cycles(6);                          // Any stray strobe fails in the monitor
    for (int n = 0; n < 10; n++) begin
      random_row(ntm_forget_pkg::row_t'(n + 40), d);
      drive_row(d);
    end
    wait_drain();

    if (exp_q.size() != 0) begin
      $display("Rows left unchecked at end of run");
      abort_run();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== ntm_forget_gate.f ====
source/ntm_forget_pkg.sv
source/ntm_gate_products.sv
source/ntm_gate_accumulate.sv
source/ntm_logistic_plan.sv
source/ntm_forget_gate_vector.sv
dv/ntm_forget_gate_asserts.sv
dv/ntm_forget_gate_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the forget gate testbench with Verilator.
# Result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module ntm_forget_gate_tb \
  -f ntm_forget_gate.f \
  -o ntm_forget_gate_sim

status=0
./obj_dir/ntm_forget_gate_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "run_sim: testbench reported failure, see $LOG"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "run_sim: simulator exited with status $status, see $LOG"
  exit 1
fi

echo "run_sim: done"

// ==== source/ntm_forget_gate_vector.sv ====
/* Forget gate row pipeline, f(l) = logistic(W*x + K*r + U*h + b). Three cycles
   from in_strobe to out_strobe, one row per cycle, no stall; reset drops rows */
`default_nettype none

module ntm_forget_gate_vector (
  // Global
  input  logic                      CLK,
  input  logic                      RST,

  // One row per strobe
  input  logic                      in_strobe,
  input  ntm_forget_pkg::gate_in_t  in_data,

  // Gate value, tagged with its row
  output logic                      out_strobe,
  output ntm_forget_pkg::gate_out_t out_data
);

  ///////////////////////////////////////////////////////////////////////
  // Stage links
  ///////////////////////////////////////////////////////////////////////

  logic                        p_strobe;     // Stage 1 to 2
  ntm_forget_pkg::prod_stage_t p_data;
  logic                        a_strobe;     // Stage 2 to 3
  ntm_forget_pkg::pre_stage_t  a_data;

  // Multipliers
  ntm_gate_products u_products (
    .CLK       (CLK),
    .RST       (RST),
    .in_strobe (in_strobe),
    .in_data   (in_data),
    .p_strobe  (p_strobe),
    .p_data    (p_data)
  );

  // Adder tree and bias
  ntm_gate_accumulate u_accumulate (
    .CLK      (CLK),
    .RST      (RST),
    .p_strobe (p_strobe),
    .p_data   (p_data),
    .a_strobe (a_strobe),
    .a_data   (a_data)
  );

  // Logistic
  ntm_logistic_plan u_logistic (
    .CLK        (CLK),
    .RST        (RST),
    .a_strobe   (a_strobe),
    .a_data     (a_data),
    .out_strobe (out_strobe),
    .out_data   (out_data)
  );

endmodule

`default_nettype wire

// ==== source/ntm_forget_pkg.sv ====
/* Fixed-point types and constants for the forget gate pipeline. The vector length is fixed
   at compile time and the adder tree in stage 2 is sized for VEC_LEN of 4 */
`default_nettype none

package ntm_forget_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Sizes
  ///////////////////////////////////////////////////////////////////////

  localparam int VEC_LEN  = 4;               // Elements per operand vector
  localparam int FRAC_IN  = 4;               // Q4.4 inputs
  localparam int FRAC_ACC = 8;               // Products and sum at Q.8
  localparam int N_PROD   = 3 * VEC_LEN;     // W*x, K*r and U*h terms

  // Fixed-point element types
  typedef logic signed [7:0]  elem_t;        // Q4.4 weight, operand or bias
  typedef logic signed [15:0] prod_t;        // Q8.8 full product
  typedef logic signed [19:0] acc_t;         // Preactivation, 8 fraction bits
  typedef logic        [7:0]  gate_t;        // Q0.8, 255 means one
  typedef logic        [5:0]  row_t;         // Gate row index

  typedef elem_t [VEC_LEN-1:0] vec_t;
  typedef prod_t [VEC_LEN-1:0] prod_vec_t;

  ///////////////////////////////////////////////////////////////////////
  // Stage payloads
  ///////////////////////////////////////////////////////////////////////

  typedef struct packed {
    row_t  row;
    vec_t  w_row;                            // W(l)
    vec_t  x;                                // Controller input
    vec_t  k_row;                            // K(l)
    vec_t  r;                                // Read head vector
    vec_t  u_row;                            // U(l)
    vec_t  h;                                // Previous hidden state
    elem_t b;                                // Bias b(l)
  } gate_in_t;

  typedef struct packed {
    row_t      row;
    prod_vec_t wx;
    prod_vec_t kr;
    prod_vec_t uh;
    elem_t     b;                            // Still Q4.4 here
  } prod_stage_t;

  typedef struct packed {
    row_t row;
    acc_t z;                                 // Preactivation
  } pre_stage_t;

  typedef struct packed {
    row_t  row;
    gate_t f;
  } gate_out_t;

  ///////////////////////////////////////////////////////////////////////
  // PLAN logistic, all in acc_t units (1.0 = 256)
  ///////////////////////////////////////////////////////////////////////

  localparam acc_t PLAN_SAT     = 20'sd1280; // 5.0
  localparam acc_t PLAN_MID     = 20'sd608;  // 2.375
  localparam acc_t PLAN_LOW     = 20'sd256;  // 1.0
  localparam acc_t PLAN_OFF_HI  = 20'sd216;
  localparam acc_t PLAN_OFF_MID = 20'sd160;
  localparam acc_t PLAN_OFF_LOW = 20'sd128;  // Value at zero, one half
  localparam acc_t PLAN_ONE     = 20'sd256;
  localparam int   PLAN_SH_HI   = 5;         // Slope 1/32
  localparam int   PLAN_SH_MID  = 3;         // Slope 1/8
  localparam int   PLAN_SH_LOW  = 2;         // Slope 1/4
  localparam gate_t GATE_MAX    = 8'd255;    // One, clamped to Q0.8

endpackage

`default_nettype wire

// ==== source/ntm_gate_accumulate.sv ====
/* Stage 2 of 3. Balanced adder tree over the twelve products plus the bias
   shifted to 8 fraction bits. Tree shape assumes VEC_LEN of 4; sum is exact */
`default_nettype none

module ntm_gate_accumulate (
  input  logic                        CLK,
  input  logic                        RST,

  // Products in
  input  logic                        p_strobe,
  input  ntm_forget_pkg::prod_stage_t p_data,

  // Preactivation out, one cycle later
  output logic                        a_strobe,
  output ntm_forget_pkg::pre_stage_t  a_data
);

  ///////////////////////////////////////////////////////////////////////
  // Adder tree
  ///////////////////////////////////////////////////////////////////////

  ntm_forget_pkg::acc_t terms [ntm_forget_pkg::N_PROD];    // Leaves, sign-extended
  ntm_forget_pkg::acc_t lvl1  [ntm_forget_pkg::N_PROD/2];  // 6 pair sums
  ntm_forget_pkg::acc_t lvl2  [ntm_forget_pkg::N_PROD/4];  // 3 pair sums
  ntm_forget_pkg::acc_t bias_q8;
  ntm_forget_pkg::acc_t z_nxt;

  always_comb begin
    // Flatten the three product vectors into one list of leaves
    for (int i = 0; i < ntm_forget_pkg::VEC_LEN; i++) begin
      terms[i]                              = ntm_forget_pkg::acc_t'(p_data.wx[i]);
      terms[ntm_forget_pkg::VEC_LEN + i]    = ntm_forget_pkg::acc_t'(p_data.kr[i]);
      terms[2 * ntm_forget_pkg::VEC_LEN + i] = ntm_forget_pkg::acc_t'(p_data.uh[i]);
    end

    // Q4.4 bias to Q.8
    bias_q8 = ntm_forget_pkg::acc_t'(p_data.b)
              <<< (ntm_forget_pkg::FRAC_ACC - ntm_forget_pkg::FRAC_IN);

    for (int j = 0; j < ntm_forget_pkg::N_PROD / 2; j++) begin
      lvl1[j] = terms[2*j] + terms[2*j + 1];
    end

    for (int k = 0; k < ntm_forget_pkg::N_PROD / 4; k++) begin
      lvl2[k] = lvl1[2*k] + lvl1[2*k + 1];
    end

    // Last level, bias pairs with the odd leftover
    z_nxt = (lvl2[0] + lvl2[1]) + (lvl2[2] + bias_q8);
  end

  ///////////////////////////////////////////////////////////////////////
  // Pipeline register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_strobe <= 1'b0;
      a_data   <= '0;
    end else begin
      a_strobe   <= p_strobe;
      a_data.row <= p_data.row;
      a_data.z   <= z_nxt;                   // Worst case ~2^17.6, no overflow
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_gate_products.sv ====
/* Stage 1 of 3. Forms all twelve element-wise products at full Q8.8 precision
   and registers them with the row tag and the raw bias. No back-pressure */
`default_nettype none

module ntm_gate_products (
  input  logic                       CLK,
  input  logic                       RST,

  // Row in
  input  logic                       in_strobe,
  input  ntm_forget_pkg::gate_in_t   in_data,

  // Products out, one cycle later
  output logic                       p_strobe,
  output ntm_forget_pkg::prod_stage_t p_data
);

  ///////////////////////////////////////////////////////////////////////
  // Multipliers
  ///////////////////////////////////////////////////////////////////////

  ntm_forget_pkg::prod_stage_t prod_nxt;

  always_comb begin
    prod_nxt     = '0;
    prod_nxt.row = in_data.row;              // Tag rides along
    prod_nxt.b   = in_data.b;                // Aligned in stage 2

    // Signed 8x8 gives exact 16-bit result, Q4.4 * Q4.4 = Q8.8
    for (int i = 0; i < ntm_forget_pkg::VEC_LEN; i++) begin
      prod_nxt.wx[i] = $signed(in_data.w_row[i]) * $signed(in_data.x[i]);  // W(l)*x
      prod_nxt.kr[i] = $signed(in_data.k_row[i]) * $signed(in_data.r[i]);  // K(l)*r
      prod_nxt.uh[i] = $signed(in_data.u_row[i]) * $signed(in_data.h[i]);  // U(l)*h
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Pipeline register
  ///////////////////////////////////////////////////////////////////////

  // Products captured every cycle, valid only with p_strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      p_strobe <= 1'b0;                      // Drops anything in flight
      p_data   <= '0;
    end else begin
      p_strobe <= in_strobe;
      p_data   <= prod_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_logistic_plan.sv ====
/* Stage 3 of 3. PLAN piecewise-linear logistic, not an exact sigmoid; error stays
   within a few LSB of Q0.8. Output of one saturates to 255 */
`default_nettype none

module ntm_logistic_plan (
  input  logic                       CLK,
  input  logic                       RST,

  // Preactivation in
  input  logic                       a_strobe,
  input  ntm_forget_pkg::pre_stage_t a_data,

  // Gate value out, one cycle later
  output logic                       out_strobe,
  output ntm_forget_pkg::gate_out_t  out_data
);

  ///////////////////////////////////////////////////////////////////////
  // Segment select
  ///////////////////////////////////////////////////////////////////////

  logic                  neg;                // Preactivation below zero
  ntm_forget_pkg::acc_t  mag;                // |z|, fits since |z| << 2^19
  ntm_forget_pkg::acc_t  seg;                // PLAN on |z|, 128..256
  ntm_forget_pkg::acc_t  mirror;             // After symmetry fold
  ntm_forget_pkg::gate_t f_nxt;

  always_comb begin
    neg = a_data.z[$bits(ntm_forget_pkg::acc_t)-1];
    mag = neg ? -a_data.z : a_data.z;

    // Shift-and-add per segment, no multiplier
    if (mag >= ntm_forget_pkg::PLAN_SAT) begin
      seg = ntm_forget_pkg::PLAN_ONE;                    // Saturated
    end else if (mag >= ntm_forget_pkg::PLAN_MID) begin
      seg = (mag >>> ntm_forget_pkg::PLAN_SH_HI) + ntm_forget_pkg::PLAN_OFF_HI;
    end else if (mag >= ntm_forget_pkg::PLAN_LOW) begin
      seg = (mag >>> ntm_forget_pkg::PLAN_SH_MID) + ntm_forget_pkg::PLAN_OFF_MID;
    end else begin
      seg = (mag >>> ntm_forget_pkg::PLAN_SH_LOW) + ntm_forget_pkg::PLAN_OFF_LOW;
    end

    // sigma(-a) = 1 - sigma(a)
    mirror = neg ? (ntm_forget_pkg::PLAN_ONE - seg) : seg;

    // 256 has no Q0.8 code
    if (mirror > ntm_forget_pkg::acc_t'(ntm_forget_pkg::GATE_MAX)) begin
      f_nxt = ntm_forget_pkg::GATE_MAX;
    end else begin
      f_nxt = ntm_forget_pkg::gate_t'(mirror);
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Output register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_strobe <= 1'b0;
      out_data   <= '0;
    end else begin
      out_strobe   <= a_strobe;
      out_data.row <= a_data.row;            // Tag unchanged through all stages
      out_data.f   <= f_nxt;
    end
  end

endmodule

`default_nettype wire
